/* Makefile */
# Verilator build and run of the CSR unit testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f csr_unit.f \
		--top-module tb_csr_unit -Mdir obj_dir -o tb_csr_unit
	./obj_dir/tb_csr_unit | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* csr_unit.f */
+incdir+include
source/csr_pkg.sv
source/csr_write_stage.sv
source/csr_machine_regs.sv
source/csr_counters.sv
source/csr_read_mux.sv
source/csr_unit.sv
tests/tb_csr_unit.sv

/* include/csr_unit_cfg.svh */
`ifndef CSR_UNIT_CFG_SVH
`define CSR_UNIT_CFG_SVH

////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////

`define CSR_XLEN          32
`define CSR_CNT_WIDTH     64

////////////////////////////////////////////////////////////
// Reset and constant values
////////////////////////////////////////////////////////////

// msi, mti, mei and the 16 fast interrupts
`define CSR_IRQ_MASK      32'hFFFF_0888
`define CSR_MTVEC_RESET   32'h0000_0001   // Base 0, vectored
`define CSR_MSTATUS_RESET 32'h0000_1800   // mpp = machine
`define CSR_A_EXT         1'b0
`define CSR_MVENDORID     32'h0000_0000
`define CSR_MARCHID       32'h0000_0014
`define CSR_INHIBIT_RESET 32'h0000_0005   // mcycle and minstret held

`endif

/* source/csr_counters.sv */
`include "csr_unit_cfg.svh"

module csr_counters (
  input  logic                      clk,
  input  logic                      rst_n,
  input  csr_pkg::csr_word_u        wdata_i,
  input  logic                      we_inhibit_i,
  input  logic                      we_cycle_lo_i,
  input  logic                      we_cycle_hi_i,
  input  logic                      we_instret_lo_i,
  input  logic                      we_instret_hi_i,
  input  logic                      instret_i,       // One retired instruction
  output logic [`CSR_CNT_WIDTH-1:0] mcycle_o,
  output logic [`CSR_CNT_WIDTH-1:0] minstret_o,
  output logic [`CSR_XLEN-1:0]      inhibit_o
);

  localparam logic [`CSR_XLEN-1:0] INHIBIT_MASK = 32'h0000_0005;  // CY and IR only

  logic [`CSR_XLEN-1:0]      inhibit_q;
  logic [`CSR_CNT_WIDTH-1:0] cnt_q [2];  // 0 mcycle, 1 minstret
  logic [1:0]                we_lo;
  logic [1:0]                we_hi;
  logic [1:0]                inc_en;

  ////////////////////////////////////////////////////////////
  // mcountinhibit
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inhibit_q <= `CSR_INHIBIT_RESET;    // Counters off to save power
    end else if (we_inhibit_i) begin
      inhibit_q <= wdata_i.raw & INHIBIT_MASK;
    end
  end

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  assign we_lo  = {we_instret_lo_i, we_cycle_lo_i};
  assign we_hi  = {we_instret_hi_i, we_cycle_hi_i};
  assign inc_en = {~inhibit_q[2] & instret_i, ~inhibit_q[0]};

  for (genvar i = 0; i < 2; i++) begin : g_cnt
    // Software write wins over the increment
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[i] <= '0;
      end else if (we_lo[i]) begin
        cnt_q[i][`CSR_XLEN-1:0] <= wdata_i.raw;
      end else if (we_hi[i]) begin
        cnt_q[i][`CSR_CNT_WIDTH-1:`CSR_XLEN] <= wdata_i.raw;
      end else if (inc_en[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign mcycle_o   = cnt_q[0];
  assign minstret_o = cnt_q[1];
  assign inhibit_o  = inhibit_q;

  // Halves of one counter come from distinct addresses
  a_half_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(|(we_lo & we_hi)));

endmodule

/* source/csr_machine_regs.sv */
`include "csr_unit_cfg.svh"

module csr_machine_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_word_u   wdata_i,
  input  logic                 we_mstatus_i,
  input  logic                 we_mie_i,
  input  logic                 we_mtvec_i,
  input  logic                 we_mscratch_i,
  input  logic                 we_mepc_i,
  input  logic                 we_mcause_i,
  input  logic                 trap_save_i,      // Trap entry pulse
  input  csr_pkg::mcause_t     trap_cause_i,
  input  logic [`CSR_XLEN-1:0] trap_pc_i,
  input  logic                 mret_i,
  input  logic                 mtvec_init_i,
  input  logic [`CSR_XLEN-1:0] mtvec_addr_i,
  output logic [`CSR_XLEN-1:0] mstatus_o,
  output logic [`CSR_XLEN-1:0] mie_o,
  output logic [`CSR_XLEN-1:0] mtvec_o,
  output logic [`CSR_XLEN-1:0] mscratch_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output logic [`CSR_XLEN-1:0] mcause_o,
  output logic                 m_irq_enable_o
);

  csr_pkg::mstatus_t    mstatus_q, mstatus_n;
  csr_pkg::mtvec_t      mtvec_q, mtvec_n;
  csr_pkg::mcause_t     mcause_q, mcause_n;
  logic [`CSR_XLEN-1:0] mie_q, mie_n;
  logic [`CSR_XLEN-1:0] mscratch_q, mscratch_n;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_n;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_n  = mstatus_q;
    mtvec_n    = mtvec_q;
    mcause_n   = mcause_q;
    mie_n      = we_mie_i ? (wdata_i.raw & `CSR_IRQ_MASK) : mie_q;
    mscratch_n = we_mscratch_i ? wdata_i.raw : mscratch_q;
    mepc_n     = we_mepc_i ? {wdata_i.raw[`CSR_XLEN-1:1], 1'b0} : mepc_q;

    if (we_mcause_i) begin
      mcause_n = '{interrupt:      wdata_i.mcause.interrupt,
                   exception_code: wdata_i.mcause.exception_code,
                   default:        '0};
    end
    // Only mie and mpie are writable, mpp stays machine
    if (we_mstatus_i) begin
      mstatus_n.mie  = wdata_i.mstatus.mie;
      mstatus_n.mpie = wdata_i.mstatus.mpie;
    end

    // Trap entry overrides any CSR write
    if (trap_save_i) begin
      mstatus_n.mpie = mstatus_q.mie;   // Stack the enable
      mstatus_n.mie  = 1'b0;
      mepc_n         = trap_pc_i;
      mcause_n       = trap_cause_i;
    end else if (mret_i) begin
      mstatus_n.mie  = mstatus_q.mpie;  // Unstack
      mstatus_n.mpie = 1'b1;
    end

    // Boot address load keeps the mode
    if (mtvec_init_i) begin
      mtvec_n.addr = mtvec_addr_i[`CSR_XLEN-1:8];
    end else if (we_mtvec_i) begin
      mtvec_n.addr = wdata_i.mtvec.addr;
      mtvec_n.mode = {1'b0, wdata_i.mtvec.mode[0]};   // Direct or vectored
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= `CSR_MSTATUS_RESET;
      mtvec_q    <= `CSR_MTVEC_RESET;
      mcause_q   <= '0;
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else begin
      mstatus_q  <= mstatus_n;
      mtvec_q    <= mtvec_n;
      mcause_q   <= mcause_n;
      mie_q      <= mie_n;
      mscratch_q <= mscratch_n;
      mepc_q     <= mepc_n;
    end
  end

  assign mstatus_o      = mstatus_q;
  assign mie_o          = mie_q;
  assign mtvec_o        = mtvec_q;
  assign mscratch_o     = mscratch_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign m_irq_enable_o = mstatus_q.mie;

  // Controller never enters and leaves a trap in one cycle
  a_trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_save_i && mret_i));

endmodule

/* source/csr_pkg.sv */
`include "csr_unit_cfg.svh"

package csr_pkg;

  // Implemented CSR addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_CYCLE         = 12'hC00,  // User aliases, read only
    CSR_INSTRET       = 12'hC02,
    CSR_CYCLEH        = 12'hC80,
    CSR_INSTRETH      = 12'hC82,
    CSR_MVENDORID     = 12'hF11,
    CSR_MARCHID       = 12'hF12,
    CSR_MIMPID        = 12'hF13,
    CSR_MHARTID       = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic [18:0] zero3;
    logic [1:0]  mpp;            // Bits 12:11
    logic [2:0]  zero2;
    logic        mpie;           // Bit 7
    logic [2:0]  zero1;
    logic        mie;            // Bit 3
    logic [2:0]  zero0;
  } mstatus_t;

  typedef struct packed {
    logic        interrupt;
    logic [22:0] zero;
    logic [7:0]  exception_code;
  } mcause_t;

  typedef struct packed {
    logic [23:0] addr;           // Base, 256-byte aligned
    logic [5:0]  zero;
    logic [1:0]  mode;
  } mtvec_t;

  // One write word, seen per destination
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    mstatus_t             mstatus;
    mcause_t              mcause;
    mtvec_t               mtvec;
  } csr_word_u;

  // MXL = 1, with A, C, I and M
  parameter logic [31:0] misa_value = (32'(`CSR_A_EXT) << 0)
                                    | (32'h1 << 2)
                                    | (32'h1 << 8)
                                    | (32'h1 << 12)
                                    | (32'h1 << 30);

endpackage

/* source/csr_read_mux.sv */
`include "csr_unit_cfg.svh"

module csr_read_mux (
  input  logic                      rd_en_i,
  input  logic [11:0]               rd_addr_i,
  input  csr_pkg::csr_op_e          rd_op_i,
  input  logic [`CSR_XLEN-1:0]      mstatus_i,
  input  logic [`CSR_XLEN-1:0]      mie_i,
  input  logic [`CSR_XLEN-1:0]      mtvec_i,
  input  logic [`CSR_XLEN-1:0]      mscratch_i,
  input  logic [`CSR_XLEN-1:0]      mepc_i,
  input  logic [`CSR_XLEN-1:0]      mcause_i,
  input  logic [`CSR_CNT_WIDTH-1:0] mcycle_i,
  input  logic [`CSR_CNT_WIDTH-1:0] minstret_i,
  input  logic [`CSR_XLEN-1:0]      inhibit_i,
  input  logic [`CSR_XLEN-1:0]      mip_i,
  input  logic [`CSR_XLEN-1:0]      hart_id_i,
  output logic [`CSR_XLEN-1:0]      rdata_o,
  output logic                      illegal_o,
  output logic                      counter_read_o
);

  logic [`CSR_XLEN-1:0] rdata;
  logic                 unknown;   // Address not implemented
  logic                 cnt_hit;
  logic                 ro_write;  // Modify attempt on a read-only address

  ////////////////////////////////////////////////////////////
  // Read data select
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata   = '0;
    unknown = 1'b0;
    cnt_hit = 1'b0;
    case (rd_addr_i)
      csr_pkg::CSR_MSTATUS:       rdata = mstatus_i;
      csr_pkg::CSR_MISA:          rdata = csr_pkg::misa_value;
      csr_pkg::CSR_MIE:           rdata = mie_i;
      csr_pkg::CSR_MTVEC:         rdata = mtvec_i;
      csr_pkg::CSR_MCOUNTINHIBIT: rdata = inhibit_i;
      csr_pkg::CSR_MSCRATCH:      rdata = mscratch_i;
      csr_pkg::CSR_MEPC:          rdata = mepc_i;
      csr_pkg::CSR_MCAUSE:        rdata = mcause_i;
      csr_pkg::CSR_MIP:           rdata = mip_i & `CSR_IRQ_MASK;
      csr_pkg::CSR_MVENDORID:     rdata = `CSR_MVENDORID;
      csr_pkg::CSR_MARCHID:       rdata = `CSR_MARCHID;
      csr_pkg::CSR_MHARTID:       rdata = hart_id_i;
      csr_pkg::CSR_MIMPID,
      csr_pkg::CSR_MTVAL:         rdata = '0;   // Read as zero
      // Counter halves, machine and user names alike
      csr_pkg::CSR_MCYCLE, csr_pkg::CSR_CYCLE: begin
        rdata   = mcycle_i[`CSR_XLEN-1:0];
        cnt_hit = 1'b1;
      end
      csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_CYCLEH: begin
        rdata   = mcycle_i[`CSR_CNT_WIDTH-1:`CSR_XLEN];
        cnt_hit = 1'b1;
      end
      csr_pkg::CSR_MINSTRET, csr_pkg::CSR_INSTRET: begin
        rdata   = minstret_i[`CSR_XLEN-1:0];
        cnt_hit = 1'b1;
      end
      csr_pkg::CSR_MINSTRETH, csr_pkg::CSR_INSTRETH: begin
        rdata   = minstret_i[`CSR_CNT_WIDTH-1:`CSR_XLEN];
        cnt_hit = 1'b1;
      end
      default: unknown = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Access check
  ////////////////////////////////////////////////////////////

  // Top two address bits both set means read only
  assign ro_write = (rd_op_i != csr_pkg::CSR_OP_READ) && (rd_addr_i[11:10] == 2'b11);

  assign rdata_o        = rd_en_i ? rdata : '0;
  assign illegal_o      = rd_en_i && (unknown || ro_write);
  assign counter_read_o = rd_en_i && cnt_hit;   // For the bypass logic

endmodule

/* source/csr_unit.sv */
`include "csr_unit_cfg.svh"

module csr_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  // Read side
  input  logic                 rd_en_i,
  input  logic [11:0]          rd_addr_i,
  input  csr_pkg::csr_op_e     rd_op_i,
  // Write side
  input  logic                 wr_en_i,
  input  logic [11:0]          wr_addr_i,
  input  csr_pkg::csr_op_e     wr_op_i,
  input  logic [`CSR_XLEN-1:0] wr_operand_i,
  input  logic [`CSR_XLEN-1:0] wr_old_i,
  // Trap control
  input  logic                 trap_save_i,
  input  csr_pkg::mcause_t     trap_cause_i,
  input  logic [`CSR_XLEN-1:0] trap_pc_i,
  input  logic                 mret_i,
  input  logic [`CSR_XLEN-1:0] mip_i,
  input  logic [`CSR_XLEN-1:0] hart_id_i,
  input  logic                 mtvec_init_i,
  input  logic [`CSR_XLEN-1:0] mtvec_addr_i,
  input  logic                 instret_i,
  output logic [`CSR_XLEN-1:0] rdata_o,
  output logic                 illegal_o,
  output logic                 counter_read_o,
  output logic [`CSR_XLEN-1:0] mie_o,
  output logic                 m_irq_enable_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output logic [23:0]          mtvec_addr_o,
  output logic [1:0]           mtvec_mode_o
);

  csr_pkg::csr_word_u        wdata;
  logic                      we_mstatus, we_mie, we_mtvec, we_mscratch, we_mepc, we_mcause;
  logic                      we_inhibit, we_cycle_lo, we_cycle_hi, we_instret_lo, we_instret_hi;
  logic [`CSR_XLEN-1:0]      mstatus, mtvec, mscratch, mcause, inhibit;
  logic [`CSR_CNT_WIDTH-1:0] mcycle, minstret;

  // WB stage write path
  csr_write_stage u_write_stage (
    .clk (clk), .rst_n (rst_n),
    .wr_en_i (wr_en_i), .wr_addr_i (wr_addr_i), .wr_op_i (wr_op_i),
    .wr_operand_i (wr_operand_i), .wr_old_i (wr_old_i), .wdata_o (wdata),
    .we_mstatus_o (we_mstatus), .we_mie_o (we_mie), .we_mtvec_o (we_mtvec),
    .we_mscratch_o (we_mscratch), .we_mepc_o (we_mepc), .we_mcause_o (we_mcause),
    .we_inhibit_o (we_inhibit), .we_cycle_lo_o (we_cycle_lo), .we_cycle_hi_o (we_cycle_hi),
    .we_instret_lo_o (we_instret_lo), .we_instret_hi_o (we_instret_hi)
  );

  csr_machine_regs u_machine_regs (
    .clk (clk), .rst_n (rst_n), .wdata_i (wdata),
    .we_mstatus_i (we_mstatus), .we_mie_i (we_mie), .we_mtvec_i (we_mtvec),
    .we_mscratch_i (we_mscratch), .we_mepc_i (we_mepc), .we_mcause_i (we_mcause),
    .trap_save_i (trap_save_i), .trap_cause_i (trap_cause_i), .trap_pc_i (trap_pc_i),
    .mret_i (mret_i), .mtvec_init_i (mtvec_init_i), .mtvec_addr_i (mtvec_addr_i),
    .mstatus_o (mstatus), .mie_o (mie_o), .mtvec_o (mtvec), .mscratch_o (mscratch),
    .mepc_o (mepc_o), .mcause_o (mcause), .m_irq_enable_o (m_irq_enable_o)
  );

  csr_counters u_counters (
    .clk (clk), .rst_n (rst_n), .wdata_i (wdata), .we_inhibit_i (we_inhibit),
    .we_cycle_lo_i (we_cycle_lo), .we_cycle_hi_i (we_cycle_hi),
    .we_instret_lo_i (we_instret_lo), .we_instret_hi_i (we_instret_hi),
    .instret_i (instret_i), .mcycle_o (mcycle), .minstret_o (minstret), .inhibit_o (inhibit)
  );

  // EX stage read path
  csr_read_mux u_read_mux (
    .rd_en_i (rd_en_i), .rd_addr_i (rd_addr_i), .rd_op_i (rd_op_i),
    .mstatus_i (mstatus), .mie_i (mie_o), .mtvec_i (mtvec), .mscratch_i (mscratch),
    .mepc_i (mepc_o), .mcause_i (mcause), .mcycle_i (mcycle), .minstret_i (minstret),
    .inhibit_i (inhibit), .mip_i (mip_i), .hart_id_i (hart_id_i),
    .rdata_o (rdata_o), .illegal_o (illegal_o), .counter_read_o (counter_read_o)
  );

  assign mtvec_addr_o = mtvec[`CSR_XLEN-1:8];   // Base to the fetch unit
  assign mtvec_mode_o = mtvec[1:0];

endmodule

/* source/csr_write_stage.sv */
`include "csr_unit_cfg.svh"

module csr_write_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en_i,
  input  logic [11:0]          wr_addr_i,
  input  csr_pkg::csr_op_e     wr_op_i,
  input  logic [`CSR_XLEN-1:0] wr_operand_i,
  input  logic [`CSR_XLEN-1:0] wr_old_i,        // Value read in the earlier stage
  output csr_pkg::csr_word_u   wdata_o,
  output logic                 we_mstatus_o,
  output logic                 we_mie_o,
  output logic                 we_mtvec_o,
  output logic                 we_mscratch_o,
  output logic                 we_mepc_o,
  output logic                 we_mcause_o,
  output logic                 we_inhibit_o,
  output logic                 we_cycle_lo_o,
  output logic                 we_cycle_hi_o,
  output logic                 we_instret_lo_o,
  output logic                 we_instret_hi_o
);

  logic wr_active;  // Write that really modifies state

  ////////////////////////////////////////////////////////////
  // Write value
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (wr_op_i)
      csr_pkg::CSR_OP_SET:   wdata_o.raw = wr_operand_i | wr_old_i;
      csr_pkg::CSR_OP_CLEAR: wdata_o.raw = ~wr_operand_i & wr_old_i;
      default:               wdata_o.raw = wr_operand_i;   // Write, read don't care
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign wr_active = wr_en_i && (wr_op_i != csr_pkg::CSR_OP_READ);

  assign we_mstatus_o    = wr_active && (wr_addr_i == csr_pkg::CSR_MSTATUS);
  assign we_mie_o        = wr_active && (wr_addr_i == csr_pkg::CSR_MIE);
  assign we_mtvec_o      = wr_active && (wr_addr_i == csr_pkg::CSR_MTVEC);
  assign we_mscratch_o   = wr_active && (wr_addr_i == csr_pkg::CSR_MSCRATCH);
  assign we_mepc_o       = wr_active && (wr_addr_i == csr_pkg::CSR_MEPC);
  assign we_mcause_o     = wr_active && (wr_addr_i == csr_pkg::CSR_MCAUSE);
  assign we_inhibit_o    = wr_active && (wr_addr_i == csr_pkg::CSR_MCOUNTINHIBIT);
  // Only machine counter names; user aliases are read only
  assign we_cycle_lo_o   = wr_active && (wr_addr_i == csr_pkg::CSR_MCYCLE);
  assign we_cycle_hi_o   = wr_active && (wr_addr_i == csr_pkg::CSR_MCYCLEH);
  assign we_instret_lo_o = wr_active && (wr_addr_i == csr_pkg::CSR_MINSTRET);
  assign we_instret_hi_o = wr_active && (wr_addr_i == csr_pkg::CSR_MINSTRETH);

  // A single write never lands in two registers
  a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({we_mstatus_o, we_mie_o, we_mtvec_o, we_mscratch_o, we_mepc_o,
              we_mcause_o, we_inhibit_o, we_cycle_lo_o, we_cycle_hi_o,
              we_instret_lo_o, we_instret_hi_o}));

endmodule

/* tests/tb_csr_unit.sv */
`include "csr_unit_cfg.svh"

module tb_csr_unit;

  localparam int          PERIOD   = 20;
  localparam logic [31:0] SEED     = 32'hf147_07e4;
  localparam logic [31:0] HART_ID  = 32'h0000_0003;
  localparam logic [31:0] MISA_EXP = 32'h4000_1104 | 32'(`CSR_A_EXT);  // MXL 1, M, I, C
  // Cycle budget of each test in run order
  localparam int          BUDGET   = 4 + 10 + 14 + 8 + 16 + 40 + 10;

  logic                 clk, rst_n;
  logic                 rd_en_i, wr_en_i, trap_save_i, mret_i, mtvec_init_i, instret_i;
  logic [11:0]          rd_addr_i, wr_addr_i;
  csr_pkg::csr_op_e     rd_op_i, wr_op_i;
  csr_pkg::mcause_t     trap_cause_i;
  logic [31:0]          wr_operand_i, wr_old_i, trap_pc_i, mip_i, hart_id_i, mtvec_addr_i;
  logic [31:0]          rdata_o, mie_o, mepc_o;
  logic                 illegal_o, counter_read_o, m_irq_enable_o;
  logic [23:0]          mtvec_addr_o;
  logic [1:0]           mtvec_mode_o;
  logic                 last_illegal, last_cnt_read;   // Flags seen by the latest read
  int                   errors = 0;

  csr_unit u_csr_unit (.*);

  initial clk = 1'b0;
  always #(PERIOD/2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Access helpers that start and end on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Write lands at the rising edge in between
  task automatic write_csr(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                           input logic [31:0] operand, input logic [31:0] old = '0);
    wr_en_i      = 1'b1;
    wr_addr_i    = addr;
    wr_op_i      = op;
    wr_operand_i = operand;
    wr_old_i     = old;
    @(negedge clk);
    wr_en_i      = 1'b0;
  endtask

  task automatic read_csr(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                          output logic [31:0] data);
    rd_en_i       = 1'b1;
    rd_addr_i     = addr;
    rd_op_i       = op;
    #(PERIOD/4);                     // Read port settled by mid low phase
    data          = rdata_o;
    last_illegal  = illegal_o;
    last_cnt_read = counter_read_o;
    @(negedge clk);
    rd_en_i       = 1'b0;
  endtask

  task automatic expect_csr(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] d;
    read_csr(addr, csr_pkg::CSR_OP_READ, d);
    check_eq(name, exp, d);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    check_eq("reset illegal", 32'h0, 32'(illegal_o));     // Read port idle
    check_eq("reset counter_read", 32'h0, 32'(counter_read_o));
    check_eq("reset irq enable", 32'h0, 32'(m_irq_enable_o));
    expect_csr("reset mstatus", csr_pkg::CSR_MSTATUS, `CSR_MSTATUS_RESET);
    expect_csr("reset mtvec", csr_pkg::CSR_MTVEC, `CSR_MTVEC_RESET);
    expect_csr("reset mcountinhibit", csr_pkg::CSR_MCOUNTINHIBIT, 32'h5);
    expect_csr("reset misa", csr_pkg::CSR_MISA, MISA_EXP);
    expect_csr("reset mhartid", csr_pkg::CSR_MHARTID, HART_ID);
  endtask

  task automatic exercise_csr_ops();
    logic [31:0] v, s, c, d;
    v = $urandom;
    s = $urandom;
    c = $urandom;
    write_csr(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_OP_WRITE, v);
    expect_csr("ops write", csr_pkg::CSR_MSCRATCH, v);
    write_csr(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_OP_SET, s, v);       // Old = value read back
    read_csr(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_OP_READ, d);
    check_eq("ops set", v | s, d);
    write_csr(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_OP_CLEAR, c, d);
    expect_csr("ops clear", csr_pkg::CSR_MSCRATCH, (v | s) & ~c);
    v = $urandom | 32'h1;                                              // Odd pc exercises bit 0
    write_csr(csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_WRITE, v);
    expect_csr("ops mepc", csr_pkg::CSR_MEPC, v & 32'hFFFF_FFFE);
    v = $urandom;
    write_csr(csr_pkg::CSR_MIE, csr_pkg::CSR_OP_WRITE, v);
    expect_csr("ops mie", csr_pkg::CSR_MIE, v & `CSR_IRQ_MASK);
    check_eq("ops mie_o", v & `CSR_IRQ_MASK, mie_o);
  endtask

  task automatic probe_illegal_access();
    logic [31:0] d;
    read_csr(12'h7C0, csr_pkg::CSR_OP_READ, d);                        // Not implemented
    check_eq("illegal unknown", 32'h1, 32'(last_illegal));
    read_csr(csr_pkg::CSR_CYCLE, csr_pkg::CSR_OP_WRITE, d);
    check_eq("illegal ro write", 32'h1, 32'(last_illegal));
    read_csr(csr_pkg::CSR_CYCLE, csr_pkg::CSR_OP_READ, d);
    check_eq("illegal ro read", 32'h0, 32'(last_illegal));
    check_eq("illegal counter flag", 32'h1, 32'(last_cnt_read));
    expect_csr("illegal mtval", csr_pkg::CSR_MTVAL, 32'h0);
  endtask

  task automatic run_trap_mret();
    logic [31:0] pc;
    pc = $urandom & 32'hFFFF_FFFC;
    write_csr(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_WRITE, 32'h0000_0008);  // mie on
    check_eq("trap irq enable before", 32'h1, 32'(m_irq_enable_o));
    // Trap entry against a CSR write to mepc in the same cycle
    trap_save_i  = 1'b1;
    trap_cause_i = 32'h8000_0007;    // Machine timer interrupt
    trap_pc_i    = pc;
    write_csr(csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_WRITE, ~pc);
    trap_save_i  = 1'b0;
    check_eq("trap irq enable", 32'h0, 32'(m_irq_enable_o));
    check_eq("trap mepc_o", pc, mepc_o);
    expect_csr("trap mepc", csr_pkg::CSR_MEPC, pc);
    expect_csr("trap mcause", csr_pkg::CSR_MCAUSE, 32'h8000_0007);
    expect_csr("trap mstatus", csr_pkg::CSR_MSTATUS, `CSR_MSTATUS_RESET | 32'h80);
    mret_i = 1'b1;
    @(negedge clk);
    mret_i = 1'b0;
    check_eq("mret irq enable", 32'h1, 32'(m_irq_enable_o));
    expect_csr("mret mstatus", csr_pkg::CSR_MSTATUS, `CSR_MSTATUS_RESET | 32'h88);
    // Second mret from mie and mpie both clear
    write_csr(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_WRITE, 32'h0);
    mret_i = 1'b1;
    @(negedge clk);
    mret_i = 1'b0;
    check_eq("mret irq enable low", 32'h0, 32'(m_irq_enable_o));
    expect_csr("mret mpie", csr_pkg::CSR_MSTATUS, `CSR_MSTATUS_RESET | 32'h80);
  endtask

  task automatic count_events();
    logic [31:0] v, base, d;
    int          n;
    int          pulses;
    v      = $urandom;
    n      = 1 + int'($urandom % 8);
    pulses = 0;
    write_csr(csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_OP_CLEAR, 32'h5, 32'h5);
    write_csr(csr_pkg::CSR_MCYCLE, csr_pkg::CSR_OP_WRITE, v);
    repeat (n) @(negedge clk);                                         // n counting edges
    expect_csr("count mcycle", csr_pkg::CSR_MCYCLE, v + 32'(n));
    read_csr(csr_pkg::CSR_MINSTRET, csr_pkg::CSR_OP_READ, base);
    for (int i = 0; i < 8; i++) begin
      instret_i = 1'($urandom);
      pulses   += int'(instret_i);
      @(negedge clk);
    end
    instret_i = 1'b0;
    expect_csr("count minstret", csr_pkg::CSR_MINSTRET, base + 32'(pulses));
    // Retire events must not count while frozen
    write_csr(csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_OP_SET, 32'h5);
    read_csr(csr_pkg::CSR_MCYCLE, csr_pkg::CSR_OP_READ, v);
    read_csr(csr_pkg::CSR_MINSTRET, csr_pkg::CSR_OP_READ, base);
    instret_i = 1'b1;
    repeat (4) @(negedge clk);
    instret_i = 1'b0;
    expect_csr("freeze mcycle", csr_pkg::CSR_MCYCLE, v);
    expect_csr("freeze minstret", csr_pkg::CSR_MINSTRET, base);
    v = $urandom;
    write_csr(csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_OP_WRITE, v);
    expect_csr("count mcycleh", csr_pkg::CSR_MCYCLEH, v);
    read_csr(csr_pkg::CSR_CYCLEH, csr_pkg::CSR_OP_READ, d);           // User alias
    check_eq("count cycleh", v, d);
    check_eq("count cycleh flag", 32'h1, 32'(last_cnt_read));
  endtask

  task automatic load_mtvec();
    logic [31:0] a, d;
    a            = $urandom;
    mtvec_init_i = 1'b1;
    mtvec_addr_i = a;
    @(negedge clk);
    mtvec_init_i = 1'b0;
    read_csr(csr_pkg::CSR_MTVEC, csr_pkg::CSR_OP_READ, d);
    check_eq("mtvec init", {a[31:8], 8'h00} | (`CSR_MTVEC_RESET & 32'h3), d);  // Mode kept
    check_eq("mtvec init addr", 32'(a[31:8]), 32'(mtvec_addr_o));
    check_eq("mtvec init mode", `CSR_MTVEC_RESET & 32'h3, 32'(mtvec_mode_o));
    // Mode goes to direct, then back to vectored
    for (int m = 0; m < 2; m++) begin
      a = (($urandom | 32'h2) & 32'hFFFF_FFFE) | 32'(m);              // Mode bit 1 always set
      write_csr(csr_pkg::CSR_MTVEC, csr_pkg::CSR_OP_WRITE, a);
      read_csr(csr_pkg::CSR_MTVEC, csr_pkg::CSR_OP_READ, d);
      check_eq("mtvec write", {a[31:8], 7'b0, a[0]}, d);               // Mode bit 1 reads zero
      check_eq("mtvec write addr", 32'(a[31:8]), 32'(mtvec_addr_o));
      check_eq("mtvec write mode", 32'(m), 32'(mtvec_mode_o));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n        = 1'b0;
    {rd_en_i, wr_en_i, trap_save_i, mret_i, mtvec_init_i, instret_i} = '0;
    rd_addr_i    = '0;
    wr_addr_i    = '0;
    rd_op_i      = csr_pkg::CSR_OP_READ;
    wr_op_i      = csr_pkg::CSR_OP_READ;
    trap_cause_i = '0;
    {wr_operand_i, wr_old_i, trap_pc_i, mip_i, mtvec_addr_i} = '0;
    hart_id_i    = HART_ID;
    repeat (3) @(negedge clk);       // Reset over three cycles
    rst_n = 1'b1;
    check_reset_state();
    exercise_csr_ops();
    probe_illegal_access();
    run_trap_mret();
    count_events();
    load_mtvec();
    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Twice the cycle budget of all tests
  initial begin
    #(2 * BUDGET * PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Test FAILED");
    $finish;
  end

endmodule
